//--- common/mem_bridge_cfg.svh
`ifndef MEM_BRIDGE_CFG_SVH
`define MEM_BRIDGE_CFG_SVH

// byte address, covers the whole line memory
`define MEM_ADDR_W 12

// narrow burst beat
`define MEM_IN_DATA_W 32

// lite message data and memory line, a multiple of the beat width
`define MEM_OUT_DATA_W 128

// 256 lines of 16 bytes
`define MEM_LINES 256

`endif

//--- common/mem_pkg.sv
`include "mem_bridge_cfg.svh"

package mem_pkg;

  // both reads act alike, as do both writes
  // the uncached split is echoed in the response
  typedef enum logic [1:0]
  {
    e_mem_rd    = 2'b00,
    e_mem_wr    = 2'b01,
    e_mem_uc_rd = 2'b10,
    e_mem_uc_wr = 2'b11
  } mem_msg_e;

  // size is log2 of the byte count, 0 to 4
  // addr is aligned to the size
  typedef struct packed
  {
    mem_msg_e              msg_type;
    logic [2:0]            size;
    logic [`MEM_ADDR_W-1:0] addr;
  } mem_header_s;

endpackage

//--- common/mem_lite_if.sv
`timescale 1ns/1ns
`include "mem_bridge_cfg.svh"

// one lite message: header plus a full line of data
interface mem_lite_if
  import mem_pkg::*;
  ();

  mem_header_s                header;
  logic [`MEM_OUT_DATA_W-1:0] data;
  logic                       v;
  logic                       ready;

  // converter side
  modport master
  (
    output header,
    output data,
    output v,
    input  ready
  );

  // memory side
  modport client
  (
    input  header,
    input  data,
    input  v,
    output ready
  );

endinterface

//--- burst_to_lite/sipo_dynamic.sv
`timescale 1ns/1ns
`include "mem_bridge_cfg.svh"

module sipo_dynamic
  #(parameter int width_p   = `MEM_IN_DATA_W,
    parameter int max_els_p = `MEM_OUT_DATA_W / `MEM_IN_DATA_W)
  (
    input  logic                           clk_i,
    input  logic                           reset_i,

    input  logic [width_p-1:0]             data_i,
    input  logic                           v_i,
    output logic                           ready_o,

    // beat count minus one
    input  logic [$clog2(max_els_p)-1:0]   len_i,
    input  logic                           len_v_i,

    output logic [max_els_p*width_p-1:0]   data_o,
    output logic                           v_o,
    input  logic                           yumi_i
  );

  localparam int lg_els_lp = $clog2(max_els_p);

  typedef enum logic
  {
    e_fill = 1'b0,
    e_full = 1'b1
  } sipo_state_e;

  sipo_state_e                         state_r;
  logic [lg_els_lp-1:0]                cnt_r;
  logic [lg_els_lp-1:0]                len_r;
  logic                                len_v_r;
  logic [max_els_p-1:0][width_p-1:0]   data_r;
  logic                                beat_fire;
  logic                                last_beat;

  // beats only flow once their length is known
  assign ready_o   = (state_r == e_fill) & len_v_r;
  assign beat_fire = v_i & ready_o;
  assign last_beat = (cnt_r == len_r);

  assign data_o = data_r;
  assign v_o    = (state_r == e_full);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_fill;
      cnt_r   <= '0;
      len_v_r <= 1'b0;
    end
    else
    begin
      if (len_v_i)
        len_v_r <= 1'b1;
      else if (beat_fire && last_beat)
        len_v_r <= 1'b0;

      if (beat_fire)
        cnt_r <= last_beat ? '0 : cnt_r + 1'b1;

      case (state_r)
        e_fill:
          if (beat_fire && last_beat)
            state_r <= e_full;
        e_full:
          if (yumi_i)
            state_r <= e_fill;
        default:
          state_r <= e_fill;
      endcase
    end
  end

  // payload, least significant beat first
  always_ff @(posedge clk_i)
  begin
    if (len_v_i)
      len_r <= len_i;
    if (beat_fire)
      data_r[cnt_r] <= data_i;
  end

  a_yumi_with_v: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o);

  a_cnt_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    len_v_r |-> (cnt_r <= len_r));

endmodule

//--- burst_to_lite/burst_to_lite.sv
`timescale 1ns/1ns
`include "mem_bridge_cfg.svh"

module burst_to_lite
  import mem_pkg::*;
  (
    input  logic                      clk_i,
    input  logic                      reset_i,

    // burst header channel
    input  mem_header_s               mem_header_i,
    input  logic                      mem_header_v_i,
    output logic                      mem_header_ready_o,

    // burst data channel
    input  logic [`MEM_IN_DATA_W-1:0] mem_data_i,
    input  logic                      mem_data_v_i,
    output logic                      mem_data_ready_o,

    mem_lite_if.master                lite_o
  );

  localparam int in_bytes_lp    = `MEM_IN_DATA_W / 8;
  localparam int burst_words_lp = `MEM_OUT_DATA_W / `MEM_IN_DATA_W;
  localparam int len_w_lp       = $clog2(burst_words_lp);

  mem_header_s                 header_r;
  logic                        header_v_r;
  logic                        header_v_n;
  logic                        header_ready_r;
  logic                        hdr_fire;
  logic                        lite_fire;
  logic                        in_is_wr;
  logic                        buf_is_rd;
  logic [31:0]                 beats;
  logic [len_w_lp-1:0]         len_lo;
  logic [`MEM_OUT_DATA_W-1:0]  data_lo;
  logic                        data_v_lo;

  assign hdr_fire  = mem_header_v_i & header_ready_r;
  assign lite_fire = lite_o.v & lite_o.ready;

  assign in_is_wr  = mem_header_i.msg_type inside {e_mem_wr, e_mem_uc_wr};
  assign buf_is_rd = header_r.msg_type inside {e_mem_rd, e_mem_uc_rd};

  // beats per write, at least one even for sub-beat sizes
  always_comb
  begin
    beats = (32'd1 << mem_header_i.size) / in_bytes_lp;
    if (beats == 32'd0)
      beats = 32'd1;
    len_lo = len_w_lp'(beats - 32'd1);
  end

  // single entry header buffer
  always_comb
  begin
    header_v_n = header_v_r;
    if (hdr_fire)
      header_v_n = 1'b1;
    else if (lite_fire)
      header_v_n = 1'b0;
  end

  // ready is registered so it stays low through reset
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      header_v_r     <= 1'b0;
      header_ready_r <= 1'b0;
    end
    else
    begin
      header_v_r     <= header_v_n;
      header_ready_r <= ~header_v_n;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (hdr_fire)
      header_r <= mem_header_i;
  end

  assign mem_header_ready_o = header_ready_r;

  sipo_dynamic
    #(.width_p  (`MEM_IN_DATA_W),
      .max_els_p(burst_words_lp))
    i_sipo
    (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .data_i (mem_data_i),
      .v_i    (mem_data_v_i),
      .ready_o(mem_data_ready_o),
      .len_i  (len_lo),
      // length handed over as the write header is taken
      .len_v_i(hdr_fire & in_is_wr),
      .data_o (data_lo),
      .v_o    (data_v_lo),
      // reads never produce a data word
      .yumi_i (lite_fire & ~buf_is_rd)
    );

  assign lite_o.header = header_r;
  assign lite_o.data   = data_lo;
  assign lite_o.v      = header_v_r & (data_v_lo | buf_is_rd);

  // a stalled message keeps its header and data
  a_lite_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (lite_o.v && !lite_o.ready) |=>
      (lite_o.v && $stable(lite_o.header) && $stable(lite_o.data)));

  a_size_legal: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_header_v_i |-> (mem_header_i.size <= 3'd4));

endmodule

//--- verilog/lite_mem_ram.sv
`timescale 1ns/1ns
`include "mem_bridge_cfg.svh"

module lite_mem_ram
  import mem_pkg::*;
  (
    input  logic                       clk_i,
    input  logic                       reset_i,

    mem_lite_if.client                 lite_i,

    // response channel
    output mem_header_s                resp_header_o,
    output logic [`MEM_OUT_DATA_W-1:0] resp_data_o,
    output logic                       resp_v_o,
    input  logic                       resp_ready_i
  );

  localparam int line_bytes_lp = `MEM_OUT_DATA_W / 8;
  localparam int offset_w_lp   = $clog2(line_bytes_lp);
  localparam int line_w_lp     = $clog2(`MEM_LINES);

  logic [`MEM_OUT_DATA_W-1:0] mem_r [`MEM_LINES];

  mem_header_s                resp_header_r;
  logic [`MEM_OUT_DATA_W-1:0] resp_data_r;
  logic                       resp_v_r;
  logic                       lite_fire;
  logic                       is_wr;
  logic [line_w_lp-1:0]       line_idx;
  logic [offset_w_lp-1:0]     line_offset;
  logic [line_bytes_lp-1:0]   size_mask;
  logic [line_bytes_lp-1:0]   byte_mask;
  logic [`MEM_OUT_DATA_W-1:0] wdata;

  // one response in flight at a time
  assign lite_i.ready = ~resp_v_r;
  assign lite_fire    = lite_i.v & lite_i.ready;

  assign is_wr       = lite_i.header.msg_type inside {e_mem_wr, e_mem_uc_wr};
  assign line_idx    = lite_i.header.addr[offset_w_lp +: line_w_lp];
  assign line_offset = lite_i.header.addr[offset_w_lp-1:0];

  // 2**size bytes starting at the line offset
  always_comb
  begin
    size_mask = line_bytes_lp'((32'd1 << (32'd1 << lite_i.header.size)) - 32'd1);
    byte_mask = size_mask << line_offset;
    wdata     = lite_i.data << {line_offset, 3'b000};
  end

  always_ff @(posedge clk_i)
  begin
    if (lite_fire && is_wr)
    begin
      for (int i = 0; i < line_bytes_lp; i++)
      begin
        if (byte_mask[i])
          mem_r[line_idx][i*8 +: 8] <= wdata[i*8 +: 8];
      end
    end
  end

  // write responses carry zero data
  always_ff @(posedge clk_i)
  begin
    if (lite_fire)
    begin
      resp_header_r <= lite_i.header;
      resp_data_r   <= is_wr ? '0 : mem_r[line_idx];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (lite_fire)
      resp_v_r <= 1'b1;
    else if (resp_ready_i)
      resp_v_r <= 1'b0;
  end

  assign resp_header_o = resp_header_r;
  assign resp_data_o   = resp_data_r;
  assign resp_v_o      = resp_v_r;

  // held response must not move while stalled
  a_resp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_v_o && !resp_ready_i) |=>
      (resp_v_o && $stable(resp_header_o) && $stable(resp_data_o)));

endmodule

//--- verilog/mem_bridge_top.sv
`timescale 1ns/1ns
`include "mem_bridge_cfg.svh"

module mem_bridge_top
  import mem_pkg::*;
  (
    input  logic                       clk_i,
    input  logic                       reset_i,

    // burst header in
    input  mem_header_s                mem_header_i,
    input  logic                       mem_header_v_i,
    output logic                       mem_header_ready_o,

    // burst data in
    input  logic [`MEM_IN_DATA_W-1:0]  mem_data_i,
    input  logic                       mem_data_v_i,
    output logic                       mem_data_ready_o,

    // lite response out
    output mem_header_s                resp_header_o,
    output logic [`MEM_OUT_DATA_W-1:0] resp_data_o,
    output logic                       resp_v_o,
    input  logic                       resp_ready_i
  );

  // converter to memory
  mem_lite_if lite_if ();

  burst_to_lite i_burst_to_lite
  (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .mem_header_i      (mem_header_i),
    .mem_header_v_i    (mem_header_v_i),
    .mem_header_ready_o(mem_header_ready_o),
    .mem_data_i        (mem_data_i),
    .mem_data_v_i      (mem_data_v_i),
    .mem_data_ready_o  (mem_data_ready_o),
    .lite_o            (lite_if.master)
  );

  lite_mem_ram i_lite_mem_ram
  (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .lite_i       (lite_if.client),
    .resp_header_o(resp_header_o),
    .resp_data_o  (resp_data_o),
    .resp_v_o     (resp_v_o),
    .resp_ready_i (resp_ready_i)
  );

endmodule

//--- dv/tb_mem_bridge.sv
`timescale 1ns/1ns
`include "mem_bridge_cfg.svh"

module tb_mem_bridge
  import mem_pkg::*;
  ();

  localparam int beat_bytes_lp = `MEM_IN_DATA_W / 8;
  localparam int off_w_lp      = $clog2(`MEM_OUT_DATA_W / 8);
  localparam int num_init_lp   = 8;
  localparam int num_txn_lp    = 168;
  localparam int max_beats_lp  = num_txn_lp * (`MEM_OUT_DATA_W / `MEM_IN_DATA_W);
  localparam int timeout_lp    = 500;

  logic                       clk_i = 1'b0;
  logic                       reset_i;
  mem_header_s                mem_header_i;
  logic                       mem_header_v_i;
  logic                       mem_header_ready_o;
  logic [`MEM_IN_DATA_W-1:0]  mem_data_i;
  logic                       mem_data_v_i;
  logic                       mem_data_ready_o;
  mem_header_s                resp_header_o;
  logic [`MEM_OUT_DATA_W-1:0] resp_data_o;
  logic                       resp_v_o;
  logic                       resp_ready_i;

  // pregenerated stimulus
  mem_header_s                txn_hdr [num_txn_lp];
  int                         hdr_gap [num_txn_lp];
  int                         beats_before [num_txn_lp];
  logic [`MEM_IN_DATA_W-1:0]  beat_data [max_beats_lp];
  int                         beat_gap [max_beats_lp];
  logic                       rdy_pat [1024];

  // reference model and expected responses
  logic [`MEM_OUT_DATA_W-1:0] model_mem [`MEM_LINES];
  mem_header_s                exp_hdr_q [$];
  logic [`MEM_OUT_DATA_W-1:0] exp_data_q [$];
  mem_header_s                exp_h;
  logic [`MEM_OUT_DATA_W-1:0] exp_d;

  logic [31:0] lcg_state = 32'h2353;
  int          total_beats = 0;
  int          beat_cnt = 0;
  int          hdr_cnt = 0;
  int          resp_cnt = 0;
  int          errors = 0;
  int          cyc = 0;

  mem_bridge_top i_mem_bridge_top
  (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .mem_header_i      (mem_header_i),
    .mem_header_v_i    (mem_header_v_i),
    .mem_header_ready_o(mem_header_ready_o),
    .mem_data_i        (mem_data_i),
    .mem_data_v_i      (mem_data_v_i),
    .mem_data_ready_o  (mem_data_ready_o),
    .resp_header_o     (resp_header_o),
    .resp_data_o       (resp_data_o),
    .resp_v_o          (resp_v_o),
    .resp_ready_i      (resp_ready_i)
  );

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic stop_run();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input string what, input logic [`MEM_OUT_DATA_W-1:0] got,
                             input logic [`MEM_OUT_DATA_W-1:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("TIMEOUT at %0t ns: %s", $time, what);
    stop_run();
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // transactions, beats and expected responses in issue order
  task automatic build_stimulus();
    mem_header_s                h;
    logic [31:0]                r;
    logic [7:0]                 pool [8];
    logic [`MEM_ADDR_W-off_w_lp-1:0] line;
    logic [3:0]                 align;
    logic [`MEM_OUT_DATA_W-1:0] word;
    int                         nb;
    for (int i = 0; i < 8; i++)
    begin
      r       = lcg_next();
      pool[i] = r[31:24];
    end
    for (int k = 0; k < num_txn_lp; k++)
    begin
      r = lcg_next();
      // first fill each pooled line so reads never see unwritten data
      if (k < num_init_lp)
      begin
        line       = pool[k];
        h.msg_type = (k % 2 != 0) ? e_mem_uc_wr : e_mem_wr;
        h.size     = 3'd4;
      end
      else if (k - num_init_lp < 10)
      begin
        // one write of each size, twice over
        line       = pool[r[29:27]];
        h.msg_type = r[31] ? e_mem_uc_wr : e_mem_wr;
        h.size     = 3'((k - num_init_lp) % 5);
      end
      else
      begin
        line       = pool[r[29:27]];
        h.msg_type = mem_msg_e'(r[31:30]);
        h.size     = 3'(r[26:16] % 5);
      end
      align       = 4'((32'd1 << h.size) - 32'd1);
      h.addr      = {line, r[15:12] & ~align};
      txn_hdr[k]  = h;
      hdr_gap[k]  = r[11] ? 0 : int'(r[10:9]);
      beats_before[k] = total_beats;
      if (h.msg_type inside {e_mem_wr, e_mem_uc_wr})
      begin
        // whole beats needed to carry the bytes
        nb = ((1 << h.size) + beat_bytes_lp - 1) / beat_bytes_lp;
        word = '0;
        for (int j = 0; j < nb; j++)
        begin
          r = lcg_next();
          beat_data[total_beats] = r;
          beat_gap[total_beats]  = r[7] ? 0 : int'(r[6:5]);
          word[j*`MEM_IN_DATA_W +: `MEM_IN_DATA_W] = r;
          total_beats++;
        end
        // low bytes of the packed word land at the line offset
        for (int i = 0; i < (1 << h.size); i++)
          model_mem[line][(int'(h.addr[3:0]) + i)*8 +: 8] = word[i*8 +: 8];
        exp_hdr_q.push_back(h);
        exp_data_q.push_back('0);
      end
      else
      begin
        exp_hdr_q.push_back(h);
        exp_data_q.push_back(model_mem[line]);
      end
    end
    for (int c = 0; c < 1024; c++)
    begin
      r          = lcg_next();
      rdy_pat[c] = (r[30:29] != 2'b00);
    end
  endtask

  task automatic send_header(input int k);
    int n;
    bit fired;
    idle_cycles(hdr_gap[k]);
    mem_header_i   = txn_hdr[k];
    mem_header_v_i = 1'b1;
    n     = 0;
    fired = 1'b0;
    while (!fired)
    begin
      @(posedge clk_i);
      fired = mem_header_ready_o;
      n++;
      if (!fired && n >= timeout_lp)
        report_timeout("header channel never accepted a header");
    end
    #1;
    mem_header_v_i = 1'b0;
  endtask

  task automatic send_beat(input int b);
    int n;
    bit fired;
    idle_cycles(beat_gap[b]);
    mem_data_i   = beat_data[b];
    mem_data_v_i = 1'b1;
    n     = 0;
    fired = 1'b0;
    while (!fired)
    begin
      @(posedge clk_i);
      fired = mem_data_ready_o;
      n++;
      if (!fired && n >= timeout_lp)
        report_timeout("data channel never accepted a beat");
    end
    #1;
    mem_data_v_i = 1'b0;
  endtask

  // random back-pressure on the response channel
  always @(posedge clk_i)
  begin
    #1;
    resp_ready_i = rdy_pat[cyc % 1024];
    cyc++;
  end

  // handshake monitor
  always @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      // all earlier write beats are in, none of this one yet
      if (mem_header_v_i && mem_header_ready_o)
      begin
        check_value("beats taken before header", `MEM_OUT_DATA_W'(beat_cnt),
                    `MEM_OUT_DATA_W'(beats_before[hdr_cnt]));
        hdr_cnt++;
      end
      if (mem_data_v_i && mem_data_ready_o)
        beat_cnt++;
      if (resp_v_o && resp_ready_i)
      begin
        if (exp_hdr_q.size() == 0)
        begin
          $display("ERROR at %0t ns: a response arrived with none expected", $time);
          stop_run();
        end
        else
        begin
          exp_h = exp_hdr_q.pop_front();
          exp_d = exp_data_q.pop_front();
          check_value("response header", `MEM_OUT_DATA_W'(resp_header_o),
                      `MEM_OUT_DATA_W'(exp_h));
          check_value("response data", resp_data_o, exp_d);
          resp_cnt++;
        end
      end
    end
  end

  initial
  begin
    int  n;
    bit  seen;
    reset_i        = 1'b1;
    mem_header_i   = '0;
    mem_header_v_i = 1'b0;
    mem_data_i     = '0;
    mem_data_v_i   = 1'b0;
    resp_ready_i   = 1'b0;
    build_stimulus();

    repeat (2) @(posedge clk_i);
    check_value("header ready in reset", `MEM_OUT_DATA_W'(mem_header_ready_o), '0);
    check_value("response valid in reset", `MEM_OUT_DATA_W'(resp_v_o), '0);
    #1;
    reset_i = 1'b0;

    // ready rises in the first cycle after reset
    n    = 0;
    seen = 1'b0;
    while (!seen)
    begin
      @(posedge clk_i);
      seen = mem_header_ready_o;
      n++;
      if (!seen && n >= 2)
        report_timeout("header channel not ready in the first cycle after reset");
    end
    check_value("response valid after reset", `MEM_OUT_DATA_W'(resp_v_o), '0);
    #1;

    fork
      for (int k = 0; k < num_txn_lp; k++)
        send_header(k);
      for (int b = 0; b < total_beats; b++)
        send_beat(b);
    join

    n = 0;
    while (resp_cnt < num_txn_lp)
    begin
      @(negedge clk_i);
      n++;
      if (resp_cnt < num_txn_lp && n >= timeout_lp)
        report_timeout("responses still missing at the end of the run");
    end

    if (errors == 0)
    begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
    else
      stop_run();
  end

endmodule

//--- all.f
+incdir+common
common/mem_pkg.sv
common/mem_lite_if.sv
burst_to_lite/sipo_dynamic.sv
burst_to_lite/burst_to_lite.sv
verilog/lite_mem_ram.sv
verilog/mem_bridge_top.sv
dv/tb_mem_bridge.sv

//--- run.sh
#!/bin/sh
# compile and run the burst to lite bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_mem_bridge -Mdir obj_dir -o sim -f all.f > build.log 2>&1; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "run.sh: simulation passed"
  exit 0
fi

echo "run.sh: pass message not found in sim.log"
exit 1
